// ==== hdl/cksumPkg.sv ====
package cksumPkg;

    localparam int BYTE_W = 8;
    localparam int WORD_W = 16;                 // Two bytes per checksummed word.
    localparam int CKSUM_W = 32;                // Upper half holds B, lower half holds A.

    localparam int CKSUM_MOD = 65535;           // Fletcher-32 sums are kept modulo 2^16 - 1.

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // One word of a frame as it travels from the packer to the accumulator.
    typedef struct packed {
        logic [WORD_W-1:0] word;                // First byte of the pair sits in the upper half.
        logic              last;                // Marks the final word of a frame.
    } wordItem_t;

endpackage

// ==== hdl/byteWordPacker.sv ====
module byteWordPacker
    import cksumPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              byteValid,
    input  logic [BYTE_W-1:0] byteData,
    input  logic              byteLast,
    output logic              wordPush,
    output wordItem_t         pushItem
);

    logic [BYTE_W-1:0] highByte;
    logic              halfPending;             // An upper byte is waiting for its partner.
    logic              wordDone;

    // A word is complete on the second byte of a pair or on a last byte.
    // A last byte with nothing pending becomes a padded word on its own.
    assign wordDone = byteValid && (halfPending || byteLast);

    always_ff @(posedge clk) begin
        if (rst) begin
            wordPush    <= 1'b0;
            halfPending <= 1'b0;
        end else begin
            wordPush <= wordDone;
            if (byteValid) begin
                halfPending <= !halfPending && !byteLast;
            end
        end
    end

    // Payload registers only follow the input, so they carry no reset.
    always_ff @(posedge clk) begin
        if (byteValid) begin
            if (halfPending) begin
                pushItem.word <= {highByte, byteData};
            end else begin
                pushItem.word <= {byteData, {BYTE_W{1'b0}}};    // Odd tail, low byte padded.
            end
            pushItem.last <= byteLast;
            if (!halfPending) begin
                highByte <= byteData;
            end
        end
    end

endmodule

// ==== hdl/wordFifo.sv ====
module wordFifo
    import cksumPkg::*;
#(
    parameter type itemType = wordItem_t
)(
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  itemType pushItem,
    input  logic    pop,
    output itemType popItem,
    output logic    notEmpty
);

    localparam logic [FIFO_PTR_W-1:0] LAST_IDX = FIFO_PTR_W'(FIFO_DEPTH - 1);

    itemType               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  full;

    assign notEmpty = (count != '0);
    assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign popItem  = mem[rdPtr];               // Head entry is shown without a read cycle.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushItem;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LAST_IDX) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_IDX) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or push and pop together.
            endcase
        end
    end

    // The producer has no back-pressure, so it relies on the consumer draining fast enough.
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("wordFifo: push while full.");

    // The consumer only pops while it sees data.
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (rst) pop |-> notEmpty
    ) else $error("wordFifo: pop while empty.");

endmodule

// ==== hdl/fletcherAccumulator.sv ====
module fletcherAccumulator
    import cksumPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               notEmpty,
    input  wordItem_t          popItem,
    output logic               wordPop,
    output logic               cksumValid,
    output logic [CKSUM_W-1:0] cksum
);

    logic [WORD_W-1:0] aSum;
    logic [WORD_W-1:0] bSum;
    logic [WORD_W-1:0] aBase;
    logic [WORD_W-1:0] bNext;
    logic              enPrev;                  // A was updated on the previous edge.
    logic              lastPrev;                // That update was the final word of a frame.
    logic              publish;

    // Ones' complement add, then 65535 folded to zero so the result is a true residue.
    function automatic logic [WORD_W-1:0] modAdd(input logic [WORD_W-1:0] x,
                                                 input logic [WORD_W-1:0] y);
        logic [WORD_W:0]   sum;
        logic [WORD_W-1:0] folded;
        sum    = {1'b0, x} + {1'b0, y};
        folded = sum[WORD_W-1:0] + WORD_W'(sum[WORD_W]);   // End-around carry.
        return (folded == WORD_W'(CKSUM_MOD)) ? '0 : folded;
    endfunction

    // While B takes in the final A, a new frame may already start from zero in A.
    // A last word is held back then, so two frame ends never fall on adjacent edges.
    assign wordPop = notEmpty && !publish && !(lastPrev && popItem.last);

    assign aBase      = lastPrev ? '0 : aSum;
    assign bNext      = modAdd(bSum, aSum);
    assign cksumValid = publish;

    always_ff @(posedge clk) begin
        if (rst) begin
            aSum     <= '0;
            bSum     <= '0;
            enPrev   <= 1'b0;
            lastPrev <= 1'b0;
            publish  <= 1'b0;
        end else begin
            enPrev   <= wordPop;
            lastPrev <= wordPop && popItem.last;
            publish  <= lastPrev;
            if (wordPop) begin
                aSum <= modAdd(aBase, popItem.word);
            end else if (lastPrev) begin
                aSum <= '0;
            end
            if (lastPrev) begin
                bSum <= '0;                     // Final B goes to the output instead.
            end else if (enPrev) begin
                bSum <= bNext;                  // B lags A by one cycle.
            end
        end
    end

    // The result register holds the last checksum until the next frame ends.
    always_ff @(posedge clk) begin
        if (lastPrev) begin
            cksum <= {bNext, aSum};
        end
    end

    sumsAreResidues: assert property (
        @(posedge clk) disable iff (rst)
        (aSum != WORD_W'(CKSUM_MOD)) && (bSum != WORD_W'(CKSUM_MOD))
    ) else $error("fletcherAccumulator: a sum reached the modulus.");

    singleCyclePulse: assert property (
        @(posedge clk) disable iff (rst) cksumValid |=> !cksumValid
    ) else $error("fletcherAccumulator: cksumValid high on consecutive cycles.");

endmodule

// ==== hdl/fletcherCksumTop.sv ====
module fletcherCksumTop
    import cksumPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               byteValid,
    input  logic [BYTE_W-1:0]  byteData,
    input  logic               byteLast,
    output logic               cksumValid,
    output logic [CKSUM_W-1:0] cksum
);

    logic      wordPush;
    wordItem_t pushItem;
    logic      wordPop;
    wordItem_t popItem;
    logic      notEmpty;

    byteWordPacker i_byteWordPacker (
        .clk       (clk),
        .rst       (rst),
        .byteValid (byteValid),
        .byteData  (byteData),
        .byteLast  (byteLast),
        .wordPush  (wordPush),
        .pushItem  (pushItem)
    );

    // Absorbs the accumulator's pause at each frame end.
    wordFifo #(
        .itemType (wordItem_t)
    ) i_wordFifo (
        .clk      (clk),
        .rst      (rst),
        .push     (wordPush),
        .pushItem (pushItem),
        .pop      (wordPop),
        .popItem  (popItem),
        .notEmpty (notEmpty)
    );

    fletcherAccumulator i_fletcherAccumulator (
        .clk        (clk),
        .rst        (rst),
        .notEmpty   (notEmpty),
        .popItem    (popItem),
        .wordPop    (wordPop),
        .cksumValid (cksumValid),
        .cksum      (cksum)
    );

endmodule

// ==== tb/tbClock.sv ====
module tbClock (
    output logic clk,
    output logic rst
);

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RELEASE_DLY  = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_DLY) rst = 1'b0;              // Released off the edge like the other inputs.
    end

endmodule

// ==== tb/fletcherCksumTb.sv ====
module fletcherCksumTb
    import cksumPkg::*;
();

    localparam int DRIVE_DLY     = 4;
    localparam int RESET_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int RANDOM_FRAMES = 200;
    localparam int IDX_W         = 9;
    localparam int MAX_FRAMES    = 1 << IDX_W;

    logic               clk;
    logic               porRst;
    logic               midRst;
    logic               rst;
    logic               byteValid;
    logic [BYTE_W-1:0]  byteData;
    logic               byteLast;
    logic               cksumValid;
    logic [CKSUM_W-1:0] cksum;

    // Expected checksums wait here in frame order until the DUT publishes them.
    logic [CKSUM_W-1:0] expected [MAX_FRAMES];
    logic [IDX_W-1:0]   wrIdx = '0;
    logic [IDX_W-1:0]   rdIdx = '0;
    logic               expAvail;
    logic [CKSUM_W-1:0] expHead;

    logic [BYTE_W-1:0]  frameBytes [$];

    int valueErrors   = 0;
    int orphanErrors  = 0;
    int timeoutErrors = 0;
    int missingErrors = 0;

    assign rst      = porRst || midRst;
    assign expAvail = (wrIdx != rdIdx);
    assign expHead  = expected[rdIdx];

    tbClock i_tbClock (
        .clk (clk),
        .rst (porRst)
    );

    fletcherCksumTop i_fletcherCksumTop (
        .clk        (clk),
        .rst        (rst),
        .byteValid  (byteValid),
        .byteData   (byteData),
        .byteLast   (byteLast),
        .cksumValid (cksumValid),
        .cksum      (cksum)
    );

    // Each published checksum retires the oldest outstanding frame.
    always @(posedge clk) begin
        if (!rst && cksumValid && expAvail) begin
            rdIdx <= rdIdx + 1'b1;
        end
    end

    pulseHasFrame: assert property (
        @(posedge clk) disable iff (rst) cksumValid |-> expAvail
    ) else begin
        orphanErrors++;
        $display("cksumValid pulsed while no frame was waiting for a checksum.");
    end

    cksumMatches: assert property (
        @(posedge clk) disable iff (rst) (cksumValid && expAvail) |-> (cksum == expHead)
    ) else begin
        valueErrors++;
        $display("[FAIL] cksum expected %08h got %08h", $sampled(expHead), $sampled(cksum));
    end

    // Words are big-endian byte pairs and an odd tail gets a zero low byte.
    function automatic logic [CKSUM_W-1:0] modelChecksum();
        int unsigned a;
        int unsigned b;
        int unsigned word;
        a = 0;
        b = 0;
        for (int i = 0; i < frameBytes.size(); i += 2) begin
            word = 32'(frameBytes[i]) << BYTE_W;
            if (i + 1 < frameBytes.size()) begin
                word = word | 32'(frameBytes[i + 1]);
            end
            a = (a + word) % CKSUM_MOD;
            b = (b + a) % CKSUM_MOD;
        end
        return {b[WORD_W-1:0], a[WORD_W-1:0]};
    endfunction

    task automatic nextDriveSlot();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            nextDriveSlot();
            byteValid = 1'b0;
            byteLast  = 1'b0;
        end
    endtask

    task automatic recordExpected(input logic [CKSUM_W-1:0] value);
        expected[wrIdx] = value;
        wrIdx = wrIdx + 1'b1;
    endtask

    task automatic fillRandom(input int len);
        frameBytes.delete();
        repeat (len) frameBytes.push_back(BYTE_W'($urandom));
    endtask

    task automatic fillConst(input int len, input logic [BYTE_W-1:0] value);
        frameBytes.delete();
        repeat (len) frameBytes.push_back(value);
    endtask

    task automatic fillAlternate(input int len, input logic [BYTE_W-1:0] first,
                                 input logic [BYTE_W-1:0] second);
        frameBytes.delete();
        for (int i = 0; i < len; i++) begin
            frameBytes.push_back((i % 2 == 0) ? first : second);
        end
    endtask

    // Drives the loaded frame one byte per cycle, then leaves gap idle cycles.
    task automatic sendFrame(input int gap);
        int last;
        last = frameBytes.size() - 1;
        for (int i = 0; i <= last; i++) begin
            nextDriveSlot();
            byteValid = 1'b1;
            byteData  = frameBytes[i];
            byteLast  = (i == last);
            if (i == last) begin
                recordExpected(modelChecksum());
            end
        end
        idleCycles(gap);
    endtask

    task automatic waitResetDone();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            timeoutErrors++;
            $display("Timeout: reset was still asserted after %0d cycles.", RESET_TIMEOUT);
        end
    endtask

    task automatic waitAllPublished();
        int cycles;
        cycles = 0;
        while (expAvail && cycles < DRAIN_TIMEOUT) begin
            idleCycles(1);
            cycles++;
        end
        if (expAvail) begin
            timeoutErrors++;
            $display("Timeout: %0d checksum pulses still missing after %0d cycles.",
                     wrIdx - rdIdx, DRAIN_TIMEOUT);
        end
    endtask

    initial begin
        int len;
        int gap;
        int totalErrors;
        byteValid = 1'b0;
        byteData  = '0;
        byteLast  = 1'b0;
        midRst    = 1'b0;
        void'($urandom(32'he4406904));

        waitResetDone();
        idleCycles(20);                         // No input, so no pulse may appear.

        fillRandom(2);
        sendFrame(3);
        fillRandom(8);
        sendFrame(3);
        fillRandom(40);
        sendFrame(3);

        fillRandom(1);
        sendFrame(4);
        fillConst(1, 8'hA5);
        sendFrame(4);
        fillRandom(3);
        sendFrame(4);
        fillRandom(9);
        sendFrame(3);

        fillConst(2, 8'hFF);                    // Every word is 65535 and folds to zero.
        sendFrame(4);
        fillConst(40, 8'hFF);
        sendFrame(3);
        fillConst(7, 8'hFF);
        sendFrame(3);
        fillAlternate(20, 8'hFF, 8'hFE);
        sendFrame(3);
        fillAlternate(21, 8'hFE, 8'hFF);
        sendFrame(3);
        waitAllPublished();

        // Frames end to end, so words queue up in the FIFO during each publish pause.
        repeat (6) begin
            fillRandom(12);
            sendFrame(0);
        end
        for (int n = 4; n <= 10; n++) begin
            fillRandom(n);
            sendFrame(0);
        end
        waitAllPublished();

        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            len = 1 + int'($urandom_range(39));
            fillRandom(len);
            if (len < 4) begin
                gap = 3 + int'($urandom_range(2));  // Short frames need room for the pause.
            end else begin
                gap = int'($urandom_range(3));
            end
            sendFrame(gap);
        end
        waitAllPublished();

        // A partial frame is cut off by reset and must leave no trace.
        fillRandom(7);
        for (int i = 0; i < frameBytes.size(); i++) begin
            nextDriveSlot();
            byteValid = 1'b1;
            byteData  = frameBytes[i];
            byteLast  = 1'b0;
        end
        nextDriveSlot();
        byteValid = 1'b0;
        midRst    = 1'b1;
        idleCycles(3);
        midRst = 1'b0;
        waitResetDone();
        fillRandom(11);
        sendFrame(3);
        fillRandom(6);
        sendFrame(3);
        waitAllPublished();
        idleCycles(10);

        noFrameLeft: assert (!expAvail) else begin
            missingErrors++;
            $display("%0d frames ended without a checksum pulse.", wrIdx - rdIdx);
        end

        totalErrors = valueErrors + orphanErrors + timeoutErrors + missingErrors;
        $display("Errors: value %0d, unexpected pulse %0d, timeout %0d, missing pulse %0d",
                 valueErrors, orphanErrors, timeoutErrors, missingErrors);
        if (totalErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== fletcherCksum.f ====
hdl/cksumPkg.sv
hdl/byteWordPacker.sv
hdl/wordFifo.sv
hdl/fletcherAccumulator.sv
hdl/fletcherCksumTop.sv
tb/tbClock.sv
tb/fletcherCksumTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the Fletcher-32 testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timing --top-module fletcherCksumTb \
    -Mdir obj_dir -o fletcherCksumSim -f fletcherCksum.f > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed."; exit 1; }

./obj_dir/fletcherCksumSim > "$SIM_LOG" 2>&1 ; cat "$SIM_LOG"

# A run that stops early prints neither closing message and also counts as a failure.
grep -q "Done: errors found" "$SIM_LOG" && { echo "Simulation failed."; exit 1; }
grep -q "Done: no errors" "$SIM_LOG" \
    && { echo "Simulation passed."; exit 0; } \
    || { echo "Simulation ended without a verdict."; exit 1; }
